// ==== verilog/axi_burst_pkg.sv ====
`default_nettype none

package axi_burst_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [7:0]        len_t;   // beats minus one
    typedef logic [2:0]        size_t;  // log2 of bytes per beat

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

endpackage

`default_nettype wire

// ==== verilog/ram_write_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ram_write_if import axi_burst_pkg::*; #(
    parameter int MEM_BYTES = 128
) ();
    localparam int WA_W = $clog2(MEM_BYTES / STRB_W);

    logic            en;         // write on this edge
    logic [WA_W-1:0] word_addr;
    strb_t           strb;
    data_t           data;

    modport engine (output en, output word_addr, output strb, output data);
    modport ram    (input en, input word_addr, input strb, input data);

endinterface

`default_nettype wire

// ==== verilog/burst_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_addr_gen import axi_burst_pkg::*; (
    input  addr_t      addr,
    input  size_t      size,
    input  len_t       len,
    input  axi_burst_e burst,
    output addr_t      next_addr
);
    addr_t step;
    addr_t incr_addr;
    addr_t wrap_mask;

    assign step      = addr_t'(1) << size;
    assign incr_addr = addr + step;

    // wrap window is (len+1) beats, len+1 being a power of two
    assign wrap_mask = ((addr_t'(len) + addr_t'(1)) << size) - addr_t'(1);

    always_comb begin
        case (burst)
            BURST_FIXED: next_addr = addr;
            BURST_WRAP:  next_addr = (addr & ~wrap_mask) | (incr_addr & wrap_mask);
            default:     next_addr = incr_addr;  // incr
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/byte_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_ram import axi_burst_pkg::*; #(
    parameter int MEM_BYTES = 128
) (
    input  logic                                s_axi_aclk,
    input  logic                                s_axi_aresetn,
    ram_write_if.ram                            wr,
    input  logic                                rd_en,
    input  logic [$clog2(MEM_BYTES/STRB_W)-1:0] rd_word_addr,
    output data_t                               rd_data
);
    localparam int WORDS = MEM_BYTES / STRB_W;

    data_t mem [WORDS];

    ////////////////////////////////////////////////////////////
    // write port, cleared while in reset
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wr.strb[b]) begin
                    mem[wr.word_addr][8*b +: 8] <= wr.data[8*b +: 8];  // lane merge
                end
            end
        end
    end

    // read data holds until the next fetch
    always_ff @(posedge s_axi_aclk) begin
        if (rd_en) begin
            rd_data <= mem[rd_word_addr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/write_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_engine import axi_burst_pkg::*; #(
    parameter int MEM_BYTES = 128,
    parameter int ID_W      = 3
) (
    input  logic            s_axi_aclk,
    input  logic            s_axi_aresetn,
    input  logic [ID_W-1:0] awid,
    input  addr_t           awaddr,
    input  len_t            awlen,
    input  size_t           awsize,
    input  axi_burst_e      awburst,
    input  logic            awvalid,
    output logic            awready,
    input  data_t           wdata,
    input  strb_t           wstrb,
    input  logic            wlast,
    input  logic            wvalid,
    output logic            wready,
    output logic [ID_W-1:0] bid,
    output axi_resp_e       bresp,
    output logic            bvalid,
    input  logic            bready,
    ram_write_if.engine     ram
);
    localparam int WA_W = $clog2(MEM_BYTES / STRB_W);

    typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} wr_state_e;

    wr_state_e       state;
    logic [ID_W-1:0] id_q;
    addr_t           addr_q;
    addr_t           addr_nxt;
    len_t            len_q;
    size_t           size_q;
    axi_burst_e      burst_q;
    len_t            beat_cnt;
    logic            err_q;      // sticky, decides bresp
    logic            aw_hs;
    logic            w_hs;
    logic            b_hs;
    logic            in_range;
    logic            last_beat;

    assign aw_hs     = awvalid && awready;
    assign w_hs      = wvalid && wready;
    assign b_hs      = bvalid && bready;
    assign in_range  = addr_q < addr_t'(MEM_BYTES);
    assign last_beat = beat_cnt == len_q;

    burst_addr_gen u_addr_gen (
        .addr(addr_q), .size(size_q), .len(len_q), .burst(burst_q), .next_addr(addr_nxt)
    );

    assign ram.en        = w_hs && in_range;  // out of range beats dropped
    assign ram.word_addr = addr_q[WA_W+1:2];
    assign ram.strb      = wstrb;
    assign ram.data      = wdata;

    assign bid   = id_q;
    assign bresp = err_q ? RESP_SLVERR : RESP_OKAY;

    ////////////////////////////////////////////////////////////
    // channel control
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state   <= W_IDLE;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            case (state)
                W_IDLE: begin
                    awready <= !aw_hs;
                    if (aw_hs) begin
                        state <= W_DATA;
                    end
                end
                W_DATA: begin
                    wready <= !(w_hs && last_beat);
                    if (w_hs && last_beat) begin
                        state <= W_RESP;  // beat len+1 ends it
                    end
                end
                default: begin
                    bvalid <= !b_hs;
                    if (b_hs) begin
                        state <= W_IDLE;
                    end
                end
            endcase
        end
    end

    // burst fields and beat tracking
    always_ff @(posedge s_axi_aclk) begin
        if (aw_hs) begin
            id_q     <= awid;
            addr_q   <= awaddr;
            len_q    <= awlen;
            size_q   <= awsize;
            burst_q  <= awburst;
            beat_cnt <= '0;
            err_q    <= 1'b0;
        end else if (w_hs) begin
            addr_q   <= addr_nxt;
            beat_cnt <= beat_cnt + len_t'(1);
            // wlast that disagrees with the count is a protocol error
            if (!in_range || (wlast != last_beat)) begin
                err_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/read_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_engine import axi_burst_pkg::*; #(
    parameter int MEM_BYTES = 128,
    parameter int ID_W      = 3
) (
    input  logic                                s_axi_aclk,
    input  logic                                s_axi_aresetn,
    input  logic [ID_W-1:0]                     arid,
    input  addr_t                               araddr,
    input  len_t                                arlen,
    input  size_t                               arsize,
    input  axi_burst_e                          arburst,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [ID_W-1:0]                     rid,
    output data_t                               rdata,
    output axi_resp_e                           rresp,
    output logic                                rlast,
    output logic                                rvalid,
    input  logic                                rready,
    output logic                                rd_en,
    output logic [$clog2(MEM_BYTES/STRB_W)-1:0] rd_word_addr,
    input  data_t                               rd_data
);
    localparam int WA_W = $clog2(MEM_BYTES / STRB_W);

    typedef enum logic [1:0] {R_IDLE, R_FETCH, R_WAIT, R_SEND} rd_state_e;

    rd_state_e       state;
    logic [ID_W-1:0] id_q;
    addr_t           addr_q;
    addr_t           addr_nxt;
    len_t            len_q;
    size_t           size_q;
    axi_burst_e      burst_q;
    len_t            beat_cnt;
    logic            ar_hs;
    logic            r_hs;
    logic            in_range;
    logic            last_beat;

    assign ar_hs     = arvalid && arready;
    assign r_hs      = rvalid && rready;
    assign in_range  = addr_q < addr_t'(MEM_BYTES);
    assign last_beat = beat_cnt == len_q;

    burst_addr_gen u_addr_gen (
        .addr(addr_q), .size(size_q), .len(len_q), .burst(burst_q), .next_addr(addr_nxt)
    );

    assign rd_en        = (state == R_FETCH) && in_range;
    assign rd_word_addr = addr_q[WA_W+1:2];
    assign rid          = id_q;

    ////////////////////////////////////////////////////////////
    // idle -> fetch -> wait -> send, back to fetch per beat
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state   <= R_IDLE;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
        end else begin
            case (state)
                R_IDLE: begin
                    arready <= !ar_hs;
                    if (ar_hs) begin
                        state <= R_FETCH;
                    end
                end
                R_FETCH: state <= R_WAIT;
                R_WAIT: begin
                    rvalid <= 1'b1;
                    rlast  <= last_beat;
                    state  <= R_SEND;
                end
                default: begin
                    if (r_hs) begin
                        rvalid <= 1'b0;
                        rlast  <= 1'b0;
                        state  <= last_beat ? R_IDLE : R_FETCH;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (ar_hs) begin
            id_q     <= arid;
            addr_q   <= araddr;
            len_q    <= arlen;
            size_q   <= arsize;
            burst_q  <= arburst;
            beat_cnt <= '0;
        end else if (r_hs && !last_beat) begin
            addr_q   <= addr_nxt;
            beat_cnt <= beat_cnt + len_t'(1);
        end
        if (state == R_WAIT) begin
            rdata <= in_range ? rd_data : '0;  // whole word, master picks lanes
            rresp <= in_range ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/axi_burst_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_burst_ram import axi_burst_pkg::*; #(
    parameter int MEM_BYTES = 128,
    parameter int ID_W      = 3
) (
    input  logic            s_axi_aclk,
    input  logic            s_axi_aresetn,
    // write address
    input  logic [ID_W-1:0] s_axi_awid,
    input  addr_t           s_axi_awaddr,
    input  len_t            s_axi_awlen,
    input  size_t           s_axi_awsize,
    input  axi_burst_e      s_axi_awburst,
    input  logic            s_axi_awvalid,
    output logic            s_axi_awready,
    // write data
    input  data_t           s_axi_wdata,
    input  strb_t           s_axi_wstrb,
    input  logic            s_axi_wlast,
    input  logic            s_axi_wvalid,
    output logic            s_axi_wready,
    // write response
    output logic [ID_W-1:0] s_axi_bid,
    output axi_resp_e       s_axi_bresp,
    output logic            s_axi_bvalid,
    input  logic            s_axi_bready,
    // read address
    input  logic [ID_W-1:0] s_axi_arid,
    input  addr_t           s_axi_araddr,
    input  len_t            s_axi_arlen,
    input  size_t           s_axi_arsize,
    input  axi_burst_e      s_axi_arburst,
    input  logic            s_axi_arvalid,
    output logic            s_axi_arready,
    // read data
    output logic [ID_W-1:0] s_axi_rid,
    output data_t           s_axi_rdata,
    output axi_resp_e       s_axi_rresp,
    output logic            s_axi_rlast,
    output logic            s_axi_rvalid,
    input  logic            s_axi_rready
);
    localparam int WA_W = $clog2(MEM_BYTES / STRB_W);

    logic            rd_en;
    logic [WA_W-1:0] rd_word_addr;
    data_t           rd_data;

    ram_write_if #(.MEM_BYTES(MEM_BYTES)) ram_wr ();

    write_engine #(.MEM_BYTES(MEM_BYTES), .ID_W(ID_W)) u_write_engine (
        .s_axi_aclk(s_axi_aclk), .s_axi_aresetn(s_axi_aresetn),
        .awid(s_axi_awid), .awaddr(s_axi_awaddr), .awlen(s_axi_awlen),
        .awsize(s_axi_awsize), .awburst(s_axi_awburst),
        .awvalid(s_axi_awvalid), .awready(s_axi_awready),
        .wdata(s_axi_wdata), .wstrb(s_axi_wstrb), .wlast(s_axi_wlast),
        .wvalid(s_axi_wvalid), .wready(s_axi_wready),
        .bid(s_axi_bid), .bresp(s_axi_bresp), .bvalid(s_axi_bvalid), .bready(s_axi_bready),
        .ram(ram_wr.engine)
    );

    read_engine #(.MEM_BYTES(MEM_BYTES), .ID_W(ID_W)) u_read_engine (
        .s_axi_aclk(s_axi_aclk), .s_axi_aresetn(s_axi_aresetn),
        .arid(s_axi_arid), .araddr(s_axi_araddr), .arlen(s_axi_arlen),
        .arsize(s_axi_arsize), .arburst(s_axi_arburst),
        .arvalid(s_axi_arvalid), .arready(s_axi_arready),
        .rid(s_axi_rid), .rdata(s_axi_rdata), .rresp(s_axi_rresp),
        .rlast(s_axi_rlast), .rvalid(s_axi_rvalid), .rready(s_axi_rready),
        .rd_en(rd_en), .rd_word_addr(rd_word_addr), .rd_data(rd_data)
    );

    byte_ram #(.MEM_BYTES(MEM_BYTES)) u_byte_ram (
        .s_axi_aclk(s_axi_aclk), .s_axi_aresetn(s_axi_aresetn),
        .wr(ram_wr.ram),
        .rd_en(rd_en), .rd_word_addr(rd_word_addr), .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// ==== testbench/axi_burst_ram_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_burst_ram_properties import axi_burst_pkg::*; #(
    parameter int ID_W = 3
) (
    input  logic            s_axi_aclk,
    input  logic            s_axi_aresetn,
    input  logic            s_axi_awready,
    input  logic [ID_W-1:0] s_axi_bid,
    input  axi_resp_e       s_axi_bresp,
    input  logic            s_axi_bvalid,
    input  logic            s_axi_bready,
    input  logic [ID_W-1:0] s_axi_rid,
    input  data_t           s_axi_rdata,
    input  axi_resp_e       s_axi_rresp,
    input  logic            s_axi_rlast,
    input  logic            s_axi_rvalid,
    input  logic            s_axi_rready
);

    ////////////////////////////////////////////////////////////
    // channel stability under back-pressure
    ////////////////////////////////////////////////////////////
    b_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=>
            s_axi_bvalid && $stable(s_axi_bid) && $stable(s_axi_bresp))
        else $error("B channel changed while bready was low");

    r_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=>
            s_axi_rvalid && $stable(s_axi_rdata) && $stable(s_axi_rresp)
            && $stable(s_axi_rlast) && $stable(s_axi_rid))
        else $error("R channel changed while rready was low");

    // no new write address while a response is pending
    aw_blocked: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid |-> !s_axi_awready)
        else $error("awready high while bvalid pending");

    reset_quiet: assert property (@(posedge s_axi_aclk)
        !s_axi_aresetn |=> !s_axi_bvalid && !s_axi_rvalid)
        else $error("valid high in the cycle after reset");

endmodule

bind axi_burst_ram axi_burst_ram_properties #(.ID_W(ID_W)) u_properties (.*);

`default_nettype wire

// ==== testbench/tb_axi_burst_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_burst_ram import axi_burst_pkg::*; ();
    localparam int MEM_BYTES = 128;
    localparam int ID_W      = 3;
    localparam int IDX_W     = $clog2(MEM_BYTES);
    localparam int TMO       = 100;  // cycles per wait

    logic            s_axi_aclk = 1'b0;
    logic            s_axi_aresetn;
    logic [ID_W-1:0] s_axi_awid;
    addr_t           s_axi_awaddr;
    len_t            s_axi_awlen;
    size_t           s_axi_awsize;
    axi_burst_e      s_axi_awburst;
    logic            s_axi_awvalid;
    logic            s_axi_awready;
    data_t           s_axi_wdata;
    strb_t           s_axi_wstrb;
    logic            s_axi_wlast;
    logic            s_axi_wvalid;
    logic            s_axi_wready;
    logic [ID_W-1:0] s_axi_bid;
    axi_resp_e       s_axi_bresp;
    logic            s_axi_bvalid;
    logic            s_axi_bready;
    logic [ID_W-1:0] s_axi_arid;
    addr_t           s_axi_araddr;
    len_t            s_axi_arlen;
    size_t           s_axi_arsize;
    axi_burst_e      s_axi_arburst;
    logic            s_axi_arvalid;
    logic            s_axi_arready;
    logic [ID_W-1:0] s_axi_rid;
    data_t           s_axi_rdata;
    axi_resp_e       s_axi_rresp;
    logic            s_axi_rlast;
    logic            s_axi_rvalid;
    logic            s_axi_rready;

    logic [7:0] model [MEM_BYTES];  // expected byte image
    data_t      wdat [16];
    strb_t      wstb [16];
    int         errors    = 0;
    int         passed    = 0;
    int         failed    = 0;
    bit         timed_out = 1'b0;

    axi_burst_ram #(.MEM_BYTES(MEM_BYTES), .ID_W(ID_W)) DUT (.*);

    always #4 s_axi_aclk = ~s_axi_aclk;

    ////////////////////////////////////////////////////////////
    // reference rules and reporting
    ////////////////////////////////////////////////////////////
    function automatic addr_t beat_addr(input addr_t start, input int i, input size_t size,
                                        input int beats, input axi_burst_e burst);
        int    nbytes;
        addr_t win;
        addr_t base;
        nbytes = 1 << size;
        win    = addr_t'(beats * nbytes);
        base   = start - (start % win);
        case (burst)
            BURST_FIXED: return start;
            BURST_WRAP:  return base + ((start - base + addr_t'(i * nbytes)) % win);
            default:     return start + addr_t'(i * nbytes);
        endcase
    endfunction

    task automatic value_failed(input string name, input string what,
                                input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("FAILED %s: %s expected %h actual %h", name, what, exp, act);
    endtask

    task automatic report_timeout(input string name, input string what);
        timed_out = 1'b1;
        $display("test %s: timeout, %s never came within %0d cycles", name, what, TMO);
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before && !timed_out) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d checks failed", name, errors - errs_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bursts
    ////////////////////////////////////////////////////////////
    task automatic write_burst(input string name, input addr_t start, input int beats,
                               input size_t size, input axi_burst_e burst,
                               input logic [ID_W-1:0] id, input bit stall);
        int               n;
        addr_t            a;
        logic [IDX_W-1:0] bidx;
        bit               oob;
        oob = 1'b0;
        @(negedge s_axi_aclk);
        s_axi_awid    = id;
        s_axi_awaddr  = start;
        s_axi_awlen   = len_t'(beats - 1);
        s_axi_awsize  = size;
        s_axi_awburst = burst;
        s_axi_awvalid = 1'b1;
        n = 0;
        while (!s_axi_awready && !timed_out) begin
            @(negedge s_axi_aclk);
            n++;
            if (n == TMO) report_timeout(name, "awready");
        end
        if (timed_out) return;
        @(negedge s_axi_aclk);
        s_axi_awvalid = 1'b0;
        for (int i = 0; i < beats; i++) begin
            a = beat_addr(start, i, size, beats, burst);
            s_axi_wdata  = wdat[i];
            s_axi_wstrb  = wstb[i];
            s_axi_wlast  = (i == beats - 1);
            s_axi_wvalid = 1'b1;
            n = 0;
            while (!s_axi_wready && !timed_out) begin
                @(negedge s_axi_aclk);
                n++;
                if (n == TMO) report_timeout(name, "wready");
            end
            if (timed_out) return;
            @(negedge s_axi_aclk);
            if (a >= MEM_BYTES) begin
                oob = 1'b1;  // beat dropped
            end else begin
                for (int b = 0; b < STRB_W; b++) begin
                    bidx = IDX_W'(a & ~addr_t'(3)) + IDX_W'(b);
                    if (wstb[i][b]) model[bidx] = wdat[i][8*b +: 8];
                end
            end
        end
        s_axi_wvalid = 1'b0;
        s_axi_wlast  = 1'b0;
        s_axi_bready = stall ? 1'($urandom) : 1'b1;
        n = 0;
        while (!(s_axi_bvalid && s_axi_bready) && !timed_out) begin
            @(negedge s_axi_aclk);
            s_axi_bready = stall ? 1'($urandom) : 1'b1;
            n++;
            if (n == TMO) report_timeout(name, "B handshake");
        end
        if (timed_out) return;
        assert (s_axi_bid == id) else value_failed(name, "bid", 32'(id), 32'(s_axi_bid));
        assert (s_axi_bresp == (oob ? RESP_SLVERR : RESP_OKAY))
            else value_failed(name, "bresp", 32'(oob ? RESP_SLVERR : RESP_OKAY),
                              32'(s_axi_bresp));
        @(negedge s_axi_aclk);
        s_axi_bready = 1'b0;
    endtask

    task automatic read_burst(input string name, input addr_t start, input int beats,
                              input size_t size, input axi_burst_e burst,
                              input logic [ID_W-1:0] id, input bit stall);
        int               n;
        int               lo;
        addr_t            a;
        logic [IDX_W-1:0] bidx;
        data_t            exp;
        data_t            mask;
        axi_resp_e        exp_resp;
        @(negedge s_axi_aclk);
        s_axi_arid    = id;
        s_axi_araddr  = start;
        s_axi_arlen   = len_t'(beats - 1);
        s_axi_arsize  = size;
        s_axi_arburst = burst;
        s_axi_arvalid = 1'b1;
        n = 0;
        while (!s_axi_arready && !timed_out) begin
            @(negedge s_axi_aclk);
            n++;
            if (n == TMO) report_timeout(name, "arready");
        end
        if (timed_out) return;
        @(negedge s_axi_aclk);
        s_axi_arvalid = 1'b0;
        for (int i = 0; i < beats; i++) begin
            a = beat_addr(start, i, size, beats, burst);
            s_axi_rready = stall ? 1'($urandom) : 1'b1;
            n = 0;
            while (!(s_axi_rvalid && s_axi_rready) && !timed_out) begin
                @(negedge s_axi_aclk);
                s_axi_rready = stall ? 1'($urandom) : 1'b1;
                n++;
                if (n == TMO) report_timeout(name, "R handshake");
            end
            if (timed_out) return;
            exp      = '0;
            mask     = '1;  // whole word for out of range
            exp_resp = RESP_SLVERR;
            if (a < MEM_BYTES) begin
                lo       = int'(a[1:0]);
                mask     = '0;
                exp_resp = RESP_OKAY;
                for (int b = 0; b < STRB_W; b++) begin
                    bidx = IDX_W'(a & ~addr_t'(3)) + IDX_W'(b);
                    exp[8*b +: 8] = model[bidx];
                    if (b >= lo && b < lo + (1 << size)) mask[8*b +: 8] = 8'hff;
                end
            end
            assert ((s_axi_rdata & mask) == (exp & mask))
                else value_failed(name, $sformatf("rdata beat %0d", i), exp & mask,
                                  s_axi_rdata & mask);
            assert (s_axi_rresp == exp_resp)
                else value_failed(name, $sformatf("rresp beat %0d", i), 32'(exp_resp),
                                  32'(s_axi_rresp));
            assert (s_axi_rlast == (i == beats - 1))
                else value_failed(name, $sformatf("rlast beat %0d", i), 32'(i == beats - 1),
                                  32'(s_axi_rlast));
            assert (s_axi_rid == id) else value_failed(name, "rid", 32'(id), 32'(s_axi_rid));
            @(negedge s_axi_aclk);
        end
        s_axi_rready = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int              e;
        int              beats;
        addr_t           start;
        logic [ID_W-1:0] id;
        void'($urandom(62783));
        s_axi_aresetn = 1'b0;
        s_axi_awid    = '0;
        s_axi_awaddr  = '0;
        s_axi_awlen   = '0;
        s_axi_awsize  = '0;
        s_axi_awburst = BURST_INCR;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wlast   = 1'b0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_arid    = '0;
        s_axi_araddr  = '0;
        s_axi_arlen   = '0;
        s_axi_arsize  = '0;
        s_axi_arburst = BURST_INCR;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        for (int i = 0; i < MEM_BYTES; i++) model[i] = 8'h00;
        repeat (3) @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
        s_axi_aresetn = 1'b1;

        e = errors;
        for (int i = 0; i < 4; i++) begin
            wdat[i] = 32'ha5a5_0000 | 32'(i);
            wstb[i] = 4'hf;
        end
        write_burst("incr_burst", 32'h10, 4, 3'd2, BURST_INCR, 3'd1, 1'b0);
        read_burst("incr_burst", 32'h10, 4, 3'd2, BURST_INCR, 3'd2, 1'b0);
        end_test("incr_burst", e);

        e = errors;
        wdat[0] = 32'haabb_ccdd;
        wstb[0] = 4'hf;
        write_burst("partial_strobe", 32'h40, 1, 3'd2, BURST_INCR, 3'd3, 1'b0);
        wdat[0] = 32'h1122_3344;
        wstb[0] = 4'b0101;  // lanes 0 and 2 only
        write_burst("partial_strobe", 32'h40, 1, 3'd2, BURST_INCR, 3'd3, 1'b0);
        read_burst("partial_strobe", 32'h40, 1, 3'd2, BURST_INCR, 3'd4, 1'b0);
        end_test("partial_strobe", e);

        e = errors;
        wdat[0] = 32'h1111_1111;
        wdat[1] = 32'h2222_2222;
        wdat[2] = 32'h3333_3333;
        wstb[0] = 4'b0011;
        wstb[1] = 4'b1100;
        wstb[2] = 4'b0110;
        write_burst("fixed_burst", 32'h50, 3, 3'd2, BURST_FIXED, 3'd5, 1'b0);
        read_burst("fixed_burst", 32'h50, 3, 3'd2, BURST_FIXED, 3'd6, 1'b0);
        end_test("fixed_burst", e);

        e = errors;
        for (int i = 0; i < 4; i++) begin
            wdat[i] = 32'hc0de_0000 | 32'(i);
            wstb[i] = 4'hf;
        end
        write_burst("wrap_burst", 32'h28, 4, 3'd2, BURST_WRAP, 3'd7, 1'b0);
        read_burst("wrap_burst", 32'h20, 4, 3'd2, BURST_INCR, 3'd0, 1'b0);
        end_test("wrap_burst", e);

        e = errors;
        wdat[0] = 32'hdead_beef;
        wdat[1] = 32'hfeed_f00d;
        wstb[0] = 4'hf;
        wstb[1] = 4'hf;
        write_burst("out_of_range", 32'h7c, 2, 3'd2, BURST_INCR, 3'd2, 1'b0);
        read_burst("out_of_range", 32'h7c, 2, 3'd2, BURST_INCR, 3'd3, 1'b0);
        end_test("out_of_range", e);

        // random lengths, ids and stalls on B and R
        e = errors;
        for (int t = 0; t < 8; t++) begin
            beats = $urandom_range(1, 8);
            start = addr_t'($urandom_range(0, MEM_BYTES / 4 - beats)) << 2;
            for (int i = 0; i < beats; i++) begin
                wdat[i] = $urandom;
                wstb[i] = strb_t'($urandom);
            end
            id = ID_W'($urandom);
            write_burst("random_stall", start, beats, 3'd2, BURST_INCR, id, 1'b1);
            id = ID_W'($urandom);
            read_burst("random_stall", start, beats, 3'd2, BURST_INCR, id, 1'b1);
        end
        end_test("random_stall", e);

        $display("tests passed %0d, failed %0d, failed checks %0d, timeout %0d",
                 passed, failed, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== axi_burst_ram.f ====
verilog/axi_burst_pkg.sv
verilog/ram_write_if.sv
verilog/burst_addr_gen.sv
verilog/byte_ram.sv
verilog/write_engine.sv
verilog/read_engine.sv
verilog/axi_burst_ram.sv
testbench/axi_burst_ram_properties.sv
testbench/tb_axi_burst_ram.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the AXI burst RAM testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_axi_burst_ram \
    -f axi_burst_ram.f \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    exit 1
fi
exit 0
